// ==== list.f ====
+incdir+include
verilog/fifo_ctl_pkg.sv
verilog/stream_if.sv
verilog/sync_fifo.sv
verilog/rx_router.sv
verilog/cmd_regfile.sv
verilog/tx_arbiter.sv
verilog/fifo_ctl_top.sv
tb/fifo_ctl_asserts.sv
tb/tb_fifo_ctl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_fifo_ctl
FLIST     := list.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Some tests failed

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_fifo_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_config.svh"

module tb_fifo_ctl;

    localparam logic [1:0] TAG_LOOP_V = 2'd2;   // Echo tag
    localparam logic [1:0] TAG_CMD_V  = 2'd3;   // Read response tag

    logic        clk;
    logic        rst;
    logic [63:0] i_rx_data;
    logic        i_rx_valid;
    logic [63:0] o_tx_data;
    logic        o_tx_valid;
    logic        i_tx_ready;

    logic [63:0] out_q[$];          // Accepted output words
    logic [7:0]  ro_bytes [24];     // Expected ro map, uptime left at 0
    logic [7:0]  rw_bytes [16];     // Expected rw contents
    int          errors;
    int          start_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    fifo_ctl_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .i_rx_data  (i_rx_data),
        .i_rx_valid (i_rx_valid),
        .o_tx_data  (o_tx_data),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

    always #5 clk = ~clk;

    // Accepted beats only
    always @(posedge clk)
    begin
        if (!rst && o_tx_valid && i_tx_ready)
            out_q.push_back(o_tx_data);
    end

    // ------------------------------
    // Word builders and model
    // ------------------------------
    function automatic logic [63:0] make_loop(input logic [1:0] ctx, input logic [31:0] pl);
        return {pl, 20'h0, ctx, `FC_TYPE_LOOP, `FC_MAGIC};
    endfunction

    // Mask and value go out byte-swapped
    function automatic logic [63:0] make_cmd(input logic [1:0] ctx, input logic rd,
                                             input logic wr, input logic [15:0] addr,
                                             input logic [15:0] mask, input logic [15:0] val);
        return {val[7:0], val[15:8], mask[7:0], mask[15:8], addr, 2'b00, wr, rd,
                ctx, `FC_TYPE_CMD, `FC_MAGIC};
    endfunction

    function automatic logic [63:0] out_word(input logic [1:0] tag, input logic [1:0] ctx,
                                             input logic [31:0] pl);
        return {pl, 20'h0, ctx, tag, `FC_MAGIC};
    endfunction

    // Little-endian 16-bit value at a byte offset, zero past the end
    function automatic logic [15:0] reg_value(input logic [15:0] addr);
        int         off;
        int         size;
        logic [7:0] lo;
        logic [7:0] hi;
        off  = int'(addr[14:0]);
        size = addr[15] ? `FC_RW_BYTES : `FC_RO_BYTES;
        lo   = 8'h0;
        hi   = 8'h0;
        if (off < size)
            lo = addr[15] ? rw_bytes[off] : ro_bytes[off];
        if (off + 1 < size)
            hi = addr[15] ? rw_bytes[off + 1] : ro_bytes[off + 1];
        return {hi, lo};
    endfunction

    function automatic logic [31:0] resp_payload(input logic [15:0] addr);
        logic [15:0] v;
        v = reg_value(addr);
        return {addr, v[7:0], v[15:8]};     // Low byte goes high
    endfunction

    task automatic init_model();
        for (int i = 0; i < 24; i++)
            ro_bytes[i] = 8'h0;
        for (int i = 0; i < 16; i++)
            rw_bytes[i] = 8'h0;
        {ro_bytes[1], ro_bytes[0]} = `FC_RO_MAGIC;
        ro_bytes[4]  = 8'(`FC_RO_BYTES);
        ro_bytes[8]  = `FC_VER_MAJOR;
        ro_bytes[9]  = `FC_VER_MINOR;
        ro_bytes[10] = `FC_DEVICE_ID;
        {rw_bytes[1], rw_bytes[0]} = `FC_RW_MAGIC;
        rw_bytes[4]  = 8'(`FC_RW_BYTES);
    endtask

    // ------------------------------
    // Drivers and collectors
    // ------------------------------
    task automatic send_word(input logic [63:0] w);
        @(posedge clk);
        i_rx_data  <= w;
        i_rx_valid <= 1'b1;
    endtask

    task automatic stop_input();
        @(posedge clk);
        i_rx_valid <= 1'b0;
    endtask

    task automatic wait_words(input int n, input int limit, output bit ok);
        int cycles;
        cycles = 0;
        while (out_q.size() < n && cycles < limit)
        begin
            @(negedge clk);                 // Away from the monitor edge
            cycles++;
        end
        ok = (out_q.size() >= n);
        if (!ok)
        begin
            $display("%s: timed out with %0d of %0d output words", test_name,
                     out_q.size(), n);
            errors++;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++)
            @(negedge clk);
        assert (out_q.size() == 0)
        else
        begin
            $display("%s: %0d unexpected output words appeared", test_name, out_q.size());
            errors++;
        end
        out_q.delete();
    endtask

    task automatic check_word(input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp)
        else
        begin
            $display("ERROR %s: expected %h, got %h", test_name, exp, got);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_errors = errors;
        out_q.delete();
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != start_errors)
        begin
            tests_failed++;
            $display("%-12s FAIL (%0d errors)", test_name, errors - start_errors);
        end
        else
            $display("%-12s PASS", test_name);
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [1:0] ctx);
        bit ok;
        send_word(make_cmd(ctx, 1'b1, 1'b0, addr, 16'h0, 16'h0));
        stop_input();
        wait_words(1, 100, ok);
        if (ok)
            check_word(out_word(TAG_CMD_V, ctx, resp_payload(addr)), out_q.pop_front());
    endtask

    // Masked write, model follows the same rule
    task automatic write_reg(input logic [15:0] addr, input logic [15:0] mask,
                             input logic [15:0] val);
        int off;
        off = int'(addr[14:0]);
        send_word(make_cmd(2'd0, 1'b0, 1'b1, addr, mask, val));
        stop_input();
        if (addr[15] && off < `FC_RW_BYTES)
            rw_bytes[off] = (rw_bytes[off] & ~mask[7:0]) | (val[7:0] & mask[7:0]);
        if (addr[15] && off + 1 < `FC_RW_BYTES)
            rw_bytes[off + 1] = (rw_bytes[off + 1] & ~mask[15:8]) | (val[15:8] & mask[15:8]);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic loopback_echo();
        logic [63:0] exp_q[$];
        logic [1:0]  ctx;
        logic [31:0] pl;
        bit          ok;
        begin_test("loopback");
        for (int i = 0; i < 8; i++)
        begin
            ctx = 2'($urandom);
            pl  = $urandom;
            exp_q.push_back(out_word(TAG_LOOP_V, ctx, pl));
            send_word(make_loop(ctx, pl));
        end
        stop_input();
        wait_words(8, 200, ok);
        while (exp_q.size() > 0 && out_q.size() > 0)
            check_word(exp_q.pop_front(), out_q.pop_front());
        end_test();
    endtask

    task automatic routing_filter();
        logic [63:0] w;
        bit          ok;
        begin_test("filter");
        w = make_loop(2'd1, 32'h1111_1111);
        w[7:0] = 8'h76;                     // Bad magic
        send_word(w);
        send_word(make_loop(2'd0, 32'ha000_0001));
        w = make_cmd(2'd2, 1'b1, 1'b0, 16'h0000, 16'h0, 16'h0);
        w[9:8] = `FC_TYPE_TLP;
        send_word(w);
        w[9:8] = `FC_TYPE_CFG;
        send_word(w);
        send_word(make_loop(2'd3, 32'ha000_0002));
        w = make_cmd(2'd1, 1'b1, 1'b0, 16'h8000, 16'h0, 16'h0);
        w[7:0] = 8'h00;                     // Command with bad magic
        send_word(w);
        send_word(make_loop(2'd2, 32'ha000_0003));
        stop_input();
        wait_words(3, 100, ok);
        if (ok)
        begin
            check_word(out_word(TAG_LOOP_V, 2'd0, 32'ha000_0001), out_q.pop_front());
            check_word(out_word(TAG_LOOP_V, 2'd3, 32'ha000_0002), out_q.pop_front());
            check_word(out_word(TAG_LOOP_V, 2'd2, 32'ha000_0003), out_q.pop_front());
        end
        expect_quiet(50);
        end_test();
    endtask

    task automatic identity_reads();
        begin_test("identity");
        read_check(16'h0000, 2'($urandom));
        read_check(16'h0004, 2'($urandom));
        read_check(16'h0008, 2'($urandom));
        read_check(16'h000a, 2'($urandom));
        read_check(16'h8000, 2'($urandom));
        read_check(16'h8004, 2'($urandom));
        read_check(16'h0018, 2'($urandom)); // Past ro end
        read_check(16'h8010, 2'($urandom)); // Past rw end
        end_test();
    endtask

    task automatic masked_writes();
        logic [15:0] mask;
        begin_test("masked_wr");
        write_reg(16'h8006, 16'hffff, 16'($urandom));
        read_check(16'h8006, 2'd1);
        mask     = 16'($urandom);
        mask[0]  = 1'b1;                    // Keep it partial
        mask[15] = 1'b0;
        write_reg(16'h8006, mask, 16'($urandom));
        read_check(16'h8006, 2'd2);
        write_reg(16'h0000, 16'hffff, 16'h1234);   // ro, ignored
        read_check(16'h0000, 2'd3);
        read_check(16'h8000, 2'd0);                // Rw space untouched too
        end_test();
    endtask

    task automatic read_uptime(output logic [15:0] t);
        logic [63:0] w;
        bit          ok;
        t = 16'h0;
        send_word(make_cmd(2'd0, 1'b1, 1'b0, 16'h0010, 16'h0, 16'h0));
        stop_input();
        wait_words(1, 100, ok);
        if (ok)
        begin
            w = out_q.pop_front();
            check_word({32'h0010_0000, 20'h0, 2'd0, TAG_CMD_V, `FC_MAGIC},
                       {w[63:48], 16'h0, w[31:0]});    // Value checked by the caller
            t = {w[39:32], w[47:40]};
        end
    endtask

    task automatic uptime_advance();
        logic [15:0] t1;
        logic [15:0] t2;
        begin_test("uptime");
        read_uptime(t1);
        repeat (25) @(posedge clk);
        read_uptime(t2);
        assert (t2 > t1)
        else
        begin
            $display("%s: uptime did not advance, first %h, second %h", test_name, t1, t2);
            errors++;
        end
        end_test();
    endtask

    task automatic backpressure_mix();
        logic [63:0] loop_exp[$];
        logic [63:0] resp_exp[$];
        logic [63:0] w;
        logic [15:0] addr;
        logic [1:0]  ctx;
        logic [31:0] pl;
        bit          ok;
        begin_test("mix");
        fork
            begin
                for (int i = 0; i < 12; i++)
                begin
                    ctx = 2'($urandom);
                    pl  = $urandom;
                    loop_exp.push_back(out_word(TAG_LOOP_V, ctx, pl));
                    send_word(make_loop(ctx, pl));
                    if (i < 8)
                    begin
                        addr = {1'b1, 15'(2 * i)};
                        ctx  = 2'($urandom);
                        resp_exp.push_back(out_word(TAG_CMD_V, ctx, resp_payload(addr)));
                        send_word(make_cmd(ctx, 1'b1, 1'b0, addr, 16'h0, 16'h0));
                    end
                end
                stop_input();
            end
            begin
                repeat (60)
                begin
                    @(posedge clk);
                    i_tx_ready <= 1'($urandom);
                end
            end
        join
        @(posedge clk);
        i_tx_ready <= 1'b1;
        wait_words(loop_exp.size() + resp_exp.size(), 300, ok);
        while (out_q.size() > 0)
        begin
            w = out_q.pop_front();
            assert ((w[9:8] == TAG_LOOP_V && loop_exp.size() > 0) ||
                    (w[9:8] == TAG_CMD_V && resp_exp.size() > 0))
            else
            begin
                $display("%s: extra or mistagged output word %h", test_name, w);
                errors++;
            end
            if (w[9:8] == TAG_LOOP_V && loop_exp.size() > 0)
                check_word(loop_exp.pop_front(), w);
            else if (w[9:8] == TAG_CMD_V && resp_exp.size() > 0)
                check_word(resp_exp.pop_front(), w);
        end
        assert (loop_exp.size() == 0 && resp_exp.size() == 0)
        else
        begin
            $display("%s: %0d echo and %0d response words never arrived", test_name,
                     loop_exp.size(), resp_exp.size());
            errors++;
        end
        expect_quiet(30);                   // No late duplicates
        end_test();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        void'($urandom(43354));
        clk          = 1'b0;
        rst          = 1'b1;
        i_rx_data    = '0;
        i_rx_valid   = 1'b0;
        i_tx_ready   = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        init_model();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        loopback_echo();
        routing_filter();
        identity_reads();
        masked_writes();
        uptime_advance();
        backpressure_mix();
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
                 tests_failed, errors, u_dut.u_asserts.fail_count);
        if (tests_failed == 0 && errors == 0 && u_dut.u_asserts.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/fifo_ctl_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_config.svh"

// Checks on the host-side output handshake
module fifo_ctl_asserts (
    input logic        clk,
    input logic        rst,
    input logic [63:0] i_tx_data,
    input logic        i_tx_valid,
    input logic        i_tx_ready
);

    int fail_count = 0;             // Assertion failures so far

    // Output stage empty out of reset
    property p_idle_in_reset;
        @(posedge clk) rst |=> !i_tx_valid;
    endproperty

    // Stalled word must not change
    property p_hold_when_stalled;
        @(posedge clk) disable iff (rst)
            (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data));
    endproperty

    property p_magic_on_valid;
        @(posedge clk) disable iff (rst)
            i_tx_valid |-> (i_tx_data[7:0] == `FC_MAGIC);
    endproperty

    a_idle_in_reset: assert property (p_idle_in_reset)
        else
        begin
            fail_count++;
            $error("tx valid high while in reset");
        end
    a_hold_when_stalled: assert property (p_hold_when_stalled)
        else
        begin
            fail_count++;
            $error("tx word changed or dropped under back-pressure");
        end
    a_magic_on_valid: assert property (p_magic_on_valid)
        else
        begin
            fail_count++;
            $error("tx word without magic byte");
        end

endmodule

// Attach to every instance of the top level
bind fifo_ctl_top fifo_ctl_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .i_tx_data  (o_tx_data),
    .i_tx_valid (o_tx_valid),
    .i_tx_ready (i_tx_ready)
);

`default_nettype wire

// ==== verilog/fifo_ctl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Host-link control block
module fifo_ctl_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] i_rx_data,
    input  logic        i_rx_valid,
    output logic [63:0] o_tx_data,
    output logic        o_tx_valid,
    input  logic        i_tx_ready
);

    import fifo_ctl_pkg::*;

    // ------------------------------
    // Internal links
    // ------------------------------
    stream_if loop_s ();            // Echo path
    stream_if resp_s ();            // Read responses

    rx_word_u cmd_word;
    logic     cmd_valid;
    logic     cmd_pop;

    rx_router u_rx_router (
        .clk         (clk),
        .rst         (rst),
        .i_rx_data   (i_rx_data),
        .i_rx_valid  (i_rx_valid),
        .loop_s      (loop_s),
        .o_cmd_word  (cmd_word),
        .o_cmd_valid (cmd_valid),
        .i_cmd_pop   (cmd_pop)
    );

    cmd_regfile u_cmd_regfile (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_word  (cmd_word),
        .i_cmd_valid (cmd_valid),
        .o_cmd_pop   (cmd_pop),
        .resp_s      (resp_s)
    );

    tx_arbiter u_tx_arbiter (
        .clk         (clk),
        .rst         (rst),
        .loop_s      (loop_s),
        .resp_s      (resp_s),
        .o_tx_data   (o_tx_data),
        .o_tx_valid  (o_tx_valid),
        .i_tx_ready  (i_tx_ready)
    );

endmodule

`default_nettype wire

// ==== verilog/tx_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_config.svh"

// Fixed-priority merge onto the host output
module tx_arbiter (
    input  logic        clk,
    input  logic        rst,
    stream_if.snk       loop_s,
    stream_if.snk       resp_s,
    output logic [63:0] o_tx_data,
    output logic        o_tx_valid,
    input  logic        i_tx_ready
);

    import fifo_ctl_pkg::*;

    logic        load_en;           // Output stage free this cycle
    logic        pick_loop;
    logic        pick_resp;
    tx_tag_t     tag;
    logic [1:0]  sel_ctx;
    logic [31:0] sel_payload;

    // Empty, or current word leaves now
    assign load_en = !o_tx_valid || i_tx_ready;

    // Loopback wins over responses
    assign pick_loop = load_en && loop_s.valid;
    assign pick_resp = load_en && !loop_s.valid && resp_s.valid;

    assign loop_s.pop = pick_loop;
    assign resp_s.pop = pick_resp;

    // ------------------------------
    // Word assembly
    // ------------------------------
    assign tag         = pick_loop ? TAG_LOOP : TAG_CMD;
    assign sel_ctx     = pick_loop ? loop_s.ctx : resp_s.ctx;
    assign sel_payload = pick_loop ? loop_s.payload : resp_s.payload;

    always_ff @(posedge clk)
    begin
        if (rst)
            o_tx_valid <= 1'b0;
        else if (load_en)
            o_tx_valid <= pick_loop || pick_resp;   // Back-to-back when ready
    end

    // Held while stalled
    always_ff @(posedge clk)
    begin
        if (pick_loop || pick_resp)
            o_tx_data <= {sel_payload, 20'h0, sel_ctx, tag, `FC_MAGIC};
    end

endmodule

`default_nettype wire

// ==== verilog/cmd_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_config.svh"

// Command decoder with ro/rw register spaces
module cmd_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  fifo_ctl_pkg::rx_word_u i_cmd_word,
    input  logic                  i_cmd_valid,
    output logic                  o_cmd_pop,
    stream_if.src                 resp_s
);

    localparam int RO_W = 8 * `FC_RO_BYTES;   // 192 bits
    localparam int RW_W = 8 * `FC_RW_BYTES;   // 128 bits

    // Reset image of the rw space
    localparam logic [RW_W-1:0] RW_INIT = {
        64'h0,                      // +8: scratch
        16'h0,                      // +6: scratch
        16'(`FC_RW_BYTES),          // +4: byte count
        16'h0,                      // +2
        `FC_RW_MAGIC                // +0
    };

    logic [63:0]     uptime;
    logic [RW_W-1:0] rw_q;
    logic [RO_W-1:0] ro_vec;
    logic [15:0]     addr;
    logic [14:0]     off;
    logic [17:0]     bit_off;
    logic            in_rw;
    logic [15:0]     eff_mask;
    logic [15:0]     eff_value;
    logic [RO_W-1:0] ro_shift;
    logic [RW_W-1:0] rw_shift;
    logic [15:0]     rd_val;
    logic [RW_W-1:0] wr_mask_vec;
    logic [RW_W-1:0] wr_val_vec;
    logic            resp_afull;
    logic            resp_wr;
    logic [33:0]     resp_din;      // {ctx, addr, swapped data}
    logic [33:0]     resp_dout;

    // ------------------------------
    // Read-only space
    // ------------------------------
    assign ro_vec = {
        uptime,                     // +10: uptime, little-endian
        40'h0,                      // +B..+F
        `FC_DEVICE_ID,              // +A
        `FC_VER_MINOR,              // +9
        `FC_VER_MAJOR,              // +8
        32'(`FC_RO_BYTES),          // +4: byte count
        16'h0,                      // +2
        `FC_RO_MAGIC                // +0
    };

    // ------------------------------
    // Command decode
    // ------------------------------
    assign addr      = i_cmd_word.cmd.addr;
    assign in_rw     = addr[15];
    assign off       = addr[14:0];
    assign bit_off   = {off, 3'b000};
    assign eff_mask  = {i_cmd_word.cmd.mask_sw[7:0], i_cmd_word.cmd.mask_sw[15:8]};
    assign eff_value = {i_cmd_word.cmd.value_sw[7:0], i_cmd_word.cmd.value_sw[15:8]};

    // Hold off while response FIFO may overflow
    assign o_cmd_pop = i_cmd_valid && !resp_afull;

    // 16-bit read at byte offset, zero past the end
    assign ro_shift = ro_vec >> bit_off;
    assign rw_shift = rw_q >> bit_off;
    always_comb
    begin
        if (in_rw)
            rd_val = (off < `FC_RW_BYTES) ? rw_shift[15:0] : 16'h0;
        else
            rd_val = (off < `FC_RO_BYTES) ? ro_shift[15:0] : 16'h0;
    end

    // Write lanes placed at the byte offset
    assign wr_mask_vec = RW_W'(eff_mask) << bit_off;
    assign wr_val_vec  = RW_W'(eff_value) << bit_off;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            uptime  <= '0;
            rw_q    <= RW_INIT;
            resp_wr <= 1'b0;
        end
        else
        begin
            uptime  <= uptime + 1'b1;                   // Free running
            resp_wr <= o_cmd_pop && i_cmd_word.cmd.rd;  // Push next cycle
            if (o_cmd_pop && i_cmd_word.cmd.wr && in_rw && (off < `FC_RW_BYTES))
                rw_q <= (rw_q & ~wr_mask_vec) | (wr_val_vec & wr_mask_vec);
        end
    end

    // Response payload, low register byte goes high
    always_ff @(posedge clk)
    begin
        if (o_cmd_pop)
            resp_din <= {i_cmd_word.cmd.ctx, addr, rd_val[7:0], rd_val[15:8]};
    end

    // ------------------------------
    // Response FIFO
    // ------------------------------
    sync_fifo #(.WIDTH(34), .DEPTH(`FC_FIFO_DEPTH)) u_resp_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (resp_wr),
        .i_din         (resp_din),
        .i_rd_en       (resp_s.pop),
        .o_dout        (resp_dout),
        .o_valid       (resp_s.valid),
        .o_full        (),
        .o_almost_full (resp_afull)
    );

    assign resp_s.ctx     = resp_dout[33:32];
    assign resp_s.payload = resp_dout[31:0];

endmodule

`default_nettype wire

// ==== verilog/rx_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_config.svh"

// Input side, splits host words by magic and type
module rx_router (
    input  logic                  clk,
    input  logic                  rst,
    input  fifo_ctl_pkg::rx_word_u i_rx_data,
    input  logic                  i_rx_valid,
    stream_if.src                 loop_s,
    output fifo_ctl_pkg::rx_word_u o_cmd_word,
    output logic                  o_cmd_valid,
    input  logic                  i_cmd_pop
);

    logic        magic_ok;
    logic        is_loop;
    logic        is_cmd;
    logic        loop_full;         // Word dropped when set
    logic        cmd_full;
    logic [33:0] loop_dout;         // {ctx, payload}

    assign magic_ok = (i_rx_data.loop.magic == `FC_MAGIC);

    // ------------------------------
    // Type decode
    // ------------------------------
    always_comb
    begin
        is_loop = 1'b0;
        is_cmd  = 1'b0;
        case (i_rx_data.loop.typ)
            `FC_TYPE_LOOP: is_loop = 1'b1;
            `FC_TYPE_CMD:  is_cmd  = 1'b1;
            `FC_TYPE_TLP,
            `FC_TYPE_CFG:  ;                 // No PCIe side, discard
            default:       ;
        endcase
    end

    // ------------------------------
    // Loopback FIFO
    // ------------------------------
    sync_fifo #(.WIDTH(34), .DEPTH(`FC_FIFO_DEPTH)) u_loop_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (i_rx_valid && magic_ok && is_loop && !loop_full),
        .i_din         ({i_rx_data.loop.ctx, i_rx_data.loop.payload}),
        .i_rd_en       (loop_s.pop),
        .o_dout        (loop_dout),
        .o_valid       (loop_s.valid),
        .o_full        (loop_full),
        .o_almost_full ()
    );

    assign loop_s.ctx     = loop_dout[33:32];
    assign loop_s.payload = loop_dout[31:0];

    // ------------------------------
    // Command FIFO, whole word
    // ------------------------------
    sync_fifo #(.WIDTH(64), .DEPTH(`FC_FIFO_DEPTH)) u_cmd_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (i_rx_valid && magic_ok && is_cmd && !cmd_full),
        .i_din         (i_rx_data),
        .i_rd_en       (i_cmd_pop),
        .o_dout        (o_cmd_word),
        .o_valid       (o_cmd_valid),
        .o_full        (cmd_full),
        .o_almost_full ()
    );

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// First-word-fall-through FIFO, single clock
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_wr_en,
    input  logic [WIDTH-1:0] i_din,
    input  logic             i_rd_en,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_valid,
    output logic             o_full,
    output logic             o_almost_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];  // Storage, no reset
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;        // Occupancy, 0..DEPTH
    logic             do_wr;
    logic             do_rd;

    // Overflow and underflow requests are dropped
    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && o_valid;

    // Head is always on the output
    assign o_dout        = mem[rd_ptr];
    assign o_valid       = (count != '0);
    assign o_full        = (count == (AW+1)'(DEPTH));
    assign o_almost_full = (count >= (AW+1)'(DEPTH - 2));  // Two or fewer free

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= i_din;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or push+pop
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// FIFO head as seen by a consumer
interface stream_if;

    logic [31:0] payload;           // Head item data
    logic [1:0]  ctx;               // Head item context
    logic        valid;             // Head present
    logic        pop;               // One cycle consumes head

    // Producer side
    modport src (output payload, output ctx, output valid, input pop);

    // Consumer side
    modport snk (input payload, input ctx, input valid, output pop);

endinterface

`default_nettype wire

// ==== verilog/fifo_ctl_pkg.sv ====
`default_nettype none

package fifo_ctl_pkg;

    // ------------------------------
    // Incoming word, loopback view
    // ------------------------------
    typedef struct packed {
        logic [31:0] payload;       // Echoed unchanged
        logic [19:0] unused;
        logic [1:0]  ctx;           // Host context, returned as is
        logic [1:0]  typ;
        logic [7:0]  magic;
    } loop_word_t;

    // ------------------------------
    // Incoming word, command view
    // ------------------------------
    // Mask and value arrive byte-swapped
    typedef struct packed {
        logic [15:0] value_sw;      // Write data, bytes swapped
        logic [15:0] mask_sw;       // Write mask, bytes swapped
        logic [15:0] addr;          // [15] rw space, [14:0] byte offset
        logic [1:0]  rsvd;
        logic        wr;            // Masked write request
        logic        rd;            // Read request
        logic [1:0]  ctx;
        logic [1:0]  typ;
        logic [7:0]  magic;
    } cmd_word_t;

    // Same 64 bits, decoded by type field
    typedef union packed {
        loop_word_t loop;
        cmd_word_t  cmd;
    } rx_word_u;

    // Tag field of outgoing words
    typedef enum logic [1:0] {
        TAG_LOOP = 2'd2,
        TAG_CMD  = 2'd3
    } tx_tag_t;

endpackage

`default_nettype wire

// ==== include/fifo_ctl_config.svh ====
`ifndef FIFO_CTL_CONFIG_SVH
`define FIFO_CTL_CONFIG_SVH

// ------------------------------
// Word framing
// ------------------------------
`define FC_MAGIC        8'h77       // Low byte of every host-link word
`define FC_TYPE_TLP     2'd0        // Dropped on input
`define FC_TYPE_CFG     2'd1        // Dropped on input
`define FC_TYPE_LOOP    2'd2        // Echoed back to host
`define FC_TYPE_CMD     2'd3        // Register file access

// ------------------------------
// Register file identity
// ------------------------------
`define FC_RO_MAGIC     16'hab89
`define FC_RW_MAGIC     16'hefcd
`define FC_VER_MAJOR    8'd4
`define FC_VER_MINOR    8'd19
`define FC_DEVICE_ID    8'd3
`define FC_RO_BYTES     24          // Read-only space, bytes
`define FC_RW_BYTES     16          // Read-write space, bytes

// Shared by loopback, command and response FIFOs
`define FC_FIFO_DEPTH   16

`endif
